// File: project.f
+incdir+source
source/memCtlPkg.sv
source/phaseSequencer.sv
source/requestHold.sv
source/startControl.sv
source/coreReadTracker.sv
source/memStartTop.sv
bench/memStartTb.sv

// File: run.sh
#!/bin/bash
# Build and run the memory start controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module memStartTb \
  -f project.f -o simv > build.log 2>&1 \
  && ./obj_dir/simv > sim.log 2>&1 \
  || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; } \
  || { echo "Simulation finished without failure"; exit 0; }

// File: bench/memStartTb.sv
// Memory start controller testbench

`include "memctl_config.svh"

module memStartTb;

  localparam int NumReq = 200;
  localparam int MaxCycles = 20000;

  logic clk = 1'b0;
  logic rstN;
  logic startReq, forceBadPar, memAckn, memDataValid;
  memCtlPkg::memOpT reqOp;
  logic [`MEMCTL_WORDS-1:0] reqWords;
  logic [`MEMCTL_ADR_W-1:0] reqAdr;
  logic aChangeComing, bChangeComing, busy, memStartA, memStartB;
  logic memRdRq, memWrRq, memAdrPar, coreDataValid, coreRdInProg;
  logic [`MEMCTL_WORDS-1:0] memRq;
  logic [`MEMCTL_ADR_W-1:0] memAdr;
  logic [`MEMCTL_WADR_W-1:0] coreWordAdr;

  integer seed = 32'h4eb3;
  int errors = 0;
  int reqCount = 0;
  int cycles = 0;

  // Reference state of the controller, updated from sampled inputs.
  logic mPend, mSideB, mStartA, mStartB, mReadOut, mPulse, mRdProg, v1, v2;
  int mAckLeft;
  logic [`MEMCTL_WORDS-1:0] mWordRem;
  memCtlPkg::memOpT capOp;
  logic [`MEMCTL_WORDS-1:0] capWords;
  logic [`MEMCTL_ADR_W-1:0] capAdr;
  logic capBad;
  logic mBusy, mStrobe, mAccept, mAckAcc, mDataAcc, parOdd;

  memStartTop uut (.*);

  always #20 clk = ~clk;

  function automatic int countOnes(input logic [`MEMCTL_WORDS-1:0] m);
    int n;
    n = 0;
    for (int i = 0; i < `MEMCTL_WORDS; i++) begin
      n += int'(m[i]);
    end
    return n;
  endfunction

  function automatic logic [`MEMCTL_WADR_W-1:0] lowestSetIndex(input logic [`MEMCTL_WORDS-1:0] m);
    for (int i = 0; i < `MEMCTL_WORDS; i++) begin
      if (m[i]) return `MEMCTL_WADR_W'(i);
    end
    return '0;
  endfunction

  task automatic reportError(input string msg);
    errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  assign mBusy    = mPend || mStartA || mStartB || mReadOut;
  assign mStrobe  = mSideB ? bChangeComing : aChangeComing;
  assign mAccept  = startReq && !mBusy;
  assign mAckAcc  = memAckn && (mStartA || mStartB) && mStrobe;
  assign mDataAcc = memDataValid && mReadOut && !mPend && mStrobe;

  // The parity bit makes the count of ones odd unless a bad parity was forced.
  assign parOdd   = ^{memAdrPar, capAdr, capWords, capOp == memCtlPkg::opRead,
                      capOp == memCtlPkg::opWrite};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {mPend, mSideB, mStartA, mStartB, mReadOut, mPulse, mRdProg, v1, v2} <= '0;
      mAckLeft <= 0;
      mWordRem <= '0;
    end else begin
      mPulse <= mAccept;
      v1 <= mDataAcc;
      v2 <= v1;
      if (mAccept) begin
        mPend    <= 1'b1;
        capOp    <= reqOp;
        capWords <= reqWords;
        capAdr   <= reqAdr;
        capBad   <= forceBadPar;
        mAckLeft <= countOnes(reqWords);
        mReadOut <= (reqOp == memCtlPkg::opRead);
        mWordRem <= reqWords;
      end else if (mPend && (aChangeComing || bChangeComing)) begin
        mPend   <= 1'b0;
        mSideB  <= bChangeComing;
        mStartA <= aChangeComing;
        mStartB <= bChangeComing;
      end else if (mAckAcc) begin
        mAckLeft <= mAckLeft - 1;
        if (mAckLeft == 1) begin
          mStartA <= 1'b0;
          mStartB <= 1'b0;
        end
      end
      if (mPulse && capOp == memCtlPkg::opRead) begin
        mRdProg <= 1'b1;
      end
      // A delivered word leaves the remaining set and the last one ends the read.
      if (v2) begin
        mWordRem[lowestSetIndex(mWordRem)] <= 1'b0;
        if (countOnes(mWordRem) == 1) begin
          mReadOut <= 1'b0;
          mRdProg  <= 1'b0;
        end
      end
    end
  end

  aResetLow: assert property (@(posedge clk) $rose(rstN) |->
      !busy && !memStartA && !memStartB && !coreDataValid && !coreRdInProg)
    else reportError("outputs not low after reset");
  aNoOverlap: assert property (@(posedge clk) disable iff (!rstN) !(aChangeComing && bChangeComing))
    else reportError("change strobes coincide");
  aAtoB: assert property (@(posedge clk) disable iff (!rstN)
      aChangeComing |-> ##`MEMCTL_PHASE_LEN bChangeComing)
    else reportError("bChangeComing not one phase after aChangeComing");
  aBtoA: assert property (@(posedge clk) disable iff (!rstN)
      bChangeComing |-> ##`MEMCTL_PHASE_LEN aChangeComing)
    else reportError("aChangeComing not one phase after bChangeComing");
  aStart: assert property (@(posedge clk) disable iff (!rstN)
      memStartA == mStartA && memStartB == mStartB)
    else reportError("start lines differ from expected");
  aBusy: assert property (@(posedge clk) disable iff (!rstN) busy == mBusy)
    else reportError("busy differs from expected");
  aHold: assert property (@(posedge clk) disable iff (!rstN) busy |->
      memAdr == capAdr && memRq == capWords && parOdd == !capBad &&
      memRdRq == (capOp == memCtlPkg::opRead) && memWrRq == (capOp == memCtlPkg::opWrite))
    else reportError("held request or parity wrong");
  aValid: assert property (@(posedge clk) disable iff (!rstN) coreDataValid == v2)
    else reportError("coreDataValid not two cycles after accepted data");
  aWord: assert property (@(posedge clk) disable iff (!rstN)
      coreDataValid |-> coreWordAdr == lowestSetIndex(mWordRem))
    else reportError("coreWordAdr out of order");
  aInProg: assert property (@(posedge clk) disable iff (!rstN) coreRdInProg == mRdProg)
    else reportError("coreRdInProg differs from expected");

  // Memory model. Random pulses land on and off the strobes alike.
  always @(negedge clk) begin
    if (rstN) begin
      memAckn      <= (($random(seed) & 3) != 0);
      memDataValid <= (($random(seed) & 3) != 0);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("Errors: %0d, requests issued: %0d", errors, reqCount);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    rstN = 1'b0;
    startReq = 1'b0;
    forceBadPar = 1'b0;
    memAckn = 1'b0;
    memDataValid = 1'b0;
    reqOp = memCtlPkg::opRead;
    reqWords = '0;
    reqAdr = '0;
    repeat (16) @(negedge clk);
    rstN = 1'b1;
    repeat (3) @(negedge clk);
    while (reqCount < NumReq) begin
      while (busy) @(negedge clk);
      startReq    = 1'b1;
      reqOp       = memCtlPkg::memOpT'($random(seed) & 1);
      reqWords    = `MEMCTL_WORDS'($random(seed));
      if (reqWords == '0) reqWords = `MEMCTL_WORDS'(1);
      reqAdr      = `MEMCTL_ADR_W'($random(seed));
      forceBadPar = (($random(seed) & 7) == 0);
      reqCount++;
      @(negedge clk);
      startReq = 1'b0;
      // Leave a random gap so requests meet both phases.
      repeat ($random(seed) & 3) @(negedge clk);
    end
    while (busy) @(negedge clk);
    repeat (4) @(negedge clk);
    $display("Errors: %0d, requests issued: %0d, cycles: %0d", errors, reqCount, cycles);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: source/memStartTop.sv
// Memory start controller top

`include "memctl_config.svh"

module memStartTop (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       startReq,
  input  logic                       forceBadPar,
  input  logic                       memAckn,
  input  logic                       memDataValid,
  input  memCtlPkg::memOpT           reqOp,
  input  logic [`MEMCTL_WORDS-1:0]   reqWords,
  input  logic [`MEMCTL_ADR_W-1:0]   reqAdr,
  output logic                       aChangeComing,
  output logic                       bChangeComing,
  output logic                       busy,
  output logic                       memStartA,
  output logic                       memStartB,
  output logic                       memRdRq,
  output logic                       memWrRq,
  output logic                       memAdrPar,
  output logic                       coreDataValid,
  output logic                       coreRdInProg,
  output logic [`MEMCTL_WORDS-1:0]   memRq,
  output logic [`MEMCTL_ADR_W-1:0]   memAdr,
  output logic [`MEMCTL_WADR_W-1:0]  coreWordAdr
);

  memCtlPkg::memOpT holdOp;
  logic             startPulse;
  logic             dataAccept;
  logic             readDone;

  phaseSequencer uPhase (
    .clk           (clk),
    .rstN          (rstN),
    .phase         (),
    .aChangeComing (aChangeComing),
    .bChangeComing (bChangeComing)
  );

  // The held mask goes straight out as the bus request lines.
  requestHold uHold (
    .clk         (clk),
    .rstN        (rstN),
    .startReq    (startReq),
    .forceBadPar (forceBadPar),
    .busy        (busy),
    .reqOp       (reqOp),
    .reqWords    (reqWords),
    .reqAdr      (reqAdr),
    .holdOp      (holdOp),
    .holdWords   (memRq),
    .memAdr      (memAdr),
    .memRdRq     (memRdRq),
    .memWrRq     (memWrRq),
    .memAdrPar   (memAdrPar)
  );

  startControl uStart (
    .clk           (clk),
    .rstN          (rstN),
    .startReq      (startReq),
    .aChangeComing (aChangeComing),
    .bChangeComing (bChangeComing),
    .memAckn       (memAckn),
    .memDataValid  (memDataValid),
    .readDone      (readDone),
    .holdOp        (holdOp),
    .holdWords     (memRq),
    .startPulse    (startPulse),
    .busy          (busy),
    .memStartA     (memStartA),
    .memStartB     (memStartB),
    .ackAccept     (),
    .dataAccept    (dataAccept)
  );

  coreReadTracker uCoreRead (
    .clk           (clk),
    .rstN          (rstN),
    .startPulse    (startPulse),
    .dataAccept    (dataAccept),
    .holdOp        (holdOp),
    .holdWords     (memRq),
    .coreDataValid (coreDataValid),
    .coreRdInProg  (coreRdInProg),
    .readDone      (readDone),
    .coreWordAdr   (coreWordAdr)
  );

endmodule

// File: source/coreReadTracker.sv
// Core read data tracker

`include "memctl_config.svh"

module coreReadTracker (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       startPulse,
  input  logic                       dataAccept,
  input  memCtlPkg::memOpT           holdOp,
  input  logic [`MEMCTL_WORDS-1:0]   holdWords,
  output logic                       coreDataValid,
  output logic                       coreRdInProg,
  output logic                       readDone,
  output logic [`MEMCTL_WADR_W-1:0]  coreWordAdr
);

  logic                     validM1;
  logic                     loadRead;
  logic [`MEMCTL_WORDS-1:0] remWords;
  logic [`MEMCTL_WORDS-1:0] remNext;

  // Index of the lowest set bit, so words leave in ascending order.
  function automatic logic [`MEMCTL_WADR_W-1:0] lowIndex(input logic [`MEMCTL_WORDS-1:0] mask);
    logic [`MEMCTL_WADR_W-1:0] idx;
    idx = '0;
    for (int i = `MEMCTL_WORDS - 1; i >= 0; i--) begin
      if (mask[i]) begin
        idx = `MEMCTL_WADR_W'(i);
      end
    end
    return idx;
  endfunction

  assign loadRead    = startPulse && (holdOp == memCtlPkg::opRead);
  assign remNext     = remWords & (remWords - 1'b1);
  assign coreWordAdr = lowIndex(remWords);
  assign readDone    = coreDataValid && (remNext == '0);

  // dataAccept is the minus two stage of the core valid.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validM1       <= 1'b0;
      coreDataValid <= 1'b0;
      coreRdInProg  <= 1'b0;
    end else begin
      validM1       <= dataAccept;
      coreDataValid <= validM1;
      if (loadRead) begin
        coreRdInProg <= 1'b1;
      end else if (readDone) begin
        coreRdInProg <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (loadRead) begin
      remWords <= holdWords;
    end else if (coreDataValid) begin
      remWords <= remNext;
    end
  end

endmodule

// File: source/startControl.sv
// Memory start and acknowledge control

`include "memctl_config.svh"

module startControl (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      startReq,
  input  logic                      aChangeComing,
  input  logic                      bChangeComing,
  input  logic                      memAckn,
  input  logic                      memDataValid,
  input  logic                      readDone,
  input  memCtlPkg::memOpT          holdOp,
  input  logic [`MEMCTL_WORDS-1:0]  holdWords,
  output logic                      startPulse,
  output logic                      busy,
  output logic                      memStartA,
  output logic                      memStartB,
  output logic                      ackAccept,
  output logic                      dataAccept
);

  logic                     pending;
  logic                     sideB;
  logic                     readOut;
  logic                     accept;
  logic                     sideStrobe;
  logic                     lastAck;
  logic [`MEMCTL_WORDS-1:0] remMask;
  logic [`MEMCTL_WORDS-1:0] remNext;

  assign accept = startReq && !busy;

  // Only the strobe of the side that was started samples the bus.
  assign sideStrobe = sideB ? bChangeComing : aChangeComing;

  assign ackAccept  = memAckn && (memStartA || memStartB) && sideStrobe;
  assign dataAccept = memDataValid && readOut && !pending && sideStrobe;

  assign remNext = remMask & (remMask - 1'b1);
  assign lastAck = ackAccept && (remNext == '0);

  assign busy = pending || memStartA || memStartB || readOut;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      startPulse <= 1'b0;
      pending    <= 1'b0;
      sideB      <= 1'b0;
      memStartA  <= 1'b0;
      memStartB  <= 1'b0;
      readOut    <= 1'b0;
    end else begin
      startPulse <= accept;
      if (accept) begin
        pending <= 1'b1;
      end else if (pending && (aChangeComing || bChangeComing)) begin
        // The first strobe after the request picks the side.
        pending   <= 1'b0;
        sideB     <= !aChangeComing;
        memStartA <= aChangeComing;
        memStartB <= !aChangeComing;
      end else if (lastAck) begin
        memStartA <= 1'b0;
        memStartB <= 1'b0;
      end
      if (startPulse && holdOp == memCtlPkg::opRead) begin
        readOut <= 1'b1;
      end else if (readDone) begin
        readOut <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (startPulse) begin
      remMask <= holdWords;
    end else if (ackAccept) begin
      remMask <= remNext;
    end
  end

endmodule

// File: source/requestHold.sv
// Memory request holding register

`include "memctl_config.svh"

module requestHold (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      startReq,
  input  logic                      forceBadPar,
  input  logic                      busy,
  input  memCtlPkg::memOpT          reqOp,
  input  logic [`MEMCTL_WORDS-1:0]  reqWords,
  input  logic [`MEMCTL_ADR_W-1:0]  reqAdr,
  output memCtlPkg::memOpT          holdOp,
  output logic [`MEMCTL_WORDS-1:0]  holdWords,
  output logic [`MEMCTL_ADR_W-1:0]  memAdr,
  output logic                      memRdRq,
  output logic                      memWrRq,
  output logic                      memAdrPar
);

  logic loadReq;
  logic holdBadPar;
  logic dataPar;

  // A strobe that lands while busy is lost.
  assign loadReq = startReq && !busy;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      holdBadPar <= 1'b0;
    end else if (loadReq) begin
      holdBadPar <= forceBadPar;
    end
  end

  always_ff @(posedge clk) begin
    if (loadReq) begin
      holdOp    <= reqOp;
      holdWords <= reqWords;
      memAdr    <= reqAdr;
    end
  end

  assign memRdRq = (holdOp == memCtlPkg::opRead);
  assign memWrRq = (holdOp == memCtlPkg::opWrite);

  // Odd parity across address, mask and both request lines.
  assign dataPar   = ^{memAdr, holdWords, memRdRq, memWrRq};
  assign memAdrPar = ~dataPar ^ holdBadPar;

endmodule

// File: source/phaseSequencer.sv
// A and B phase sequencer

`include "memctl_config.svh"

module phaseSequencer (
  input  logic              clk,
  input  logic              rstN,
  output memCtlPkg::phaseT  phase,
  output logic              aChangeComing,
  output logic              bChangeComing
);

  localparam int unsigned CntW = $clog2(`MEMCTL_PHASE_LEN);
  localparam logic [CntW-1:0] LastCnt = CntW'(`MEMCTL_PHASE_LEN - 1);

  logic [CntW-1:0] phaseCnt;
  logic            lastCycle;

  assign lastCycle = (phaseCnt == LastCnt);

  // The counter wraps at the phase length and the phase flips on the wrap.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      phaseCnt <= '0;
      phase    <= memCtlPkg::phaseB;
    end else if (lastCycle) begin
      phaseCnt <= '0;
      if (phase == memCtlPkg::phaseA) begin
        phase <= memCtlPkg::phaseB;
      end else begin
        phase <= memCtlPkg::phaseA;
      end
    end else begin
      phaseCnt <= phaseCnt + 1'b1;
    end
  end

  // Each strobe announces the change into its own phase one cycle early.
  assign aChangeComing = lastCycle && (phase == memCtlPkg::phaseB);
  assign bChangeComing = lastCycle && (phase == memCtlPkg::phaseA);

endmodule

// File: source/memCtlPkg.sv
// Memory start controller types

package memCtlPkg;

  // Request opcode as held for the memory bus.
  typedef enum logic [0:0] {
    opRead  = 1'b0,
    opWrite = 1'b1
  } memOpT;

  // The interleaved bus alternates between these two phases.
  typedef enum logic [0:0] {
    phaseA = 1'b0,
    phaseB = 1'b1
  } phaseT;

endpackage

// File: source/memctl_config.svh
// Memory start controller parameters

`ifndef MEMCTL_CONFIG_SVH
`define MEMCTL_CONFIG_SVH

// Width of the held memory address.
`define MEMCTL_ADR_W 14

// Quarter words per request, one mask bit each.
`define MEMCTL_WORDS 4

// Core word address, wide enough to index a quarter word.
`define MEMCTL_WADR_W 2

// Cycles spent in each bus phase.
`define MEMCTL_PHASE_LEN 4

`endif
